// ==== project.f ====
hw/qeciphy_lane_pkg.sv
hw/qeciphy_status_pkg.sv
hw/qeciphy_word_fifo.sv
hw/qeciphy_tx_encoder.sv
hw/qeciphy_rx_decoder.sv
hw/qeciphy_link_controller.sv
hw/qeciphy_error_handler.sv
hw/qeciphy_top.sv
bench/qeciphy_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the link layer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module qeciphy_tb \
   -f project.f -o qeciphy_sim > "$BUILD_LOG" 2>&1
status=$?
cat "$BUILD_LOG"
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/qeciphy_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Result: PASSED$" "$SIM_LOG"; then
   exit 0
fi
exit 1

// ==== bench/qeciphy_tb.sv ====
// ====================
// Testbench for the PHY link layer top
// Clock, reset, lane loopback with CRC error injection
// RX stream monitor against an expected-word queue
// Directed tests for bring-up, data, back-pressure and faults
// ====================
`timescale 1ns/1ns

module qeciphy_tb;

   localparam int SEND_TIMEOUT  = 100;
   localparam int LINK_TIMEOUT  = 400;
   localparam int DRAIN_TIMEOUT = 600;
   localparam int FAULT_TIMEOUT = 300;

   logic                                    aclk;
   logic                                    reset_i;
   logic [qeciphy_lane_pkg::WORD_W-1:0]     tx_tdata_i;
   logic                                    tx_tvalid_i;
   logic                                    tx_tready_o;
   logic [qeciphy_lane_pkg::WORD_W-1:0]     rx_tdata_o;
   logic                                    rx_tvalid_o;
   logic                                    rx_tready_i;
   logic [qeciphy_status_pkg::STATUS_W-1:0] status_o;
   logic [qeciphy_status_pkg::ECODE_W-1:0]  ecode_o;
   logic                                    link_ready_o;
   logic                                    fault_fatal_o;
   logic [qeciphy_lane_pkg::LANE_W-1:0]     lane_tx;
   logic [qeciphy_lane_pkg::LANE_W-1:0]     lane_rx =
      {qeciphy_lane_pkg::HDR_CTRL, qeciphy_lane_pkg::IDLE_WORD};

   int                                  inject_req = 0;   // Bumped by a test
   int                                  inject_ack = 0;   // Bumped by the loopback
   logic                                inject_crc;
   logic [qeciphy_lane_pkg::WORD_W-1:0] expected [$];     // Words in send order
   int                                  rx_count;         // Words seen on RX
   integer                              seed;
   int                                  value_errs;
   int                                  stream_errs;
   int                                  other_errs;

   qeciphy_top u_dut (
      .aclk(aclk), .reset_i(reset_i), .tx_tdata_i(tx_tdata_i), .tx_tvalid_i(tx_tvalid_i),
      .tx_tready_o(tx_tready_o), .rx_tdata_o(rx_tdata_o), .rx_tvalid_o(rx_tvalid_o),
      .rx_tready_i(rx_tready_i), .status_o(status_o), .ecode_o(ecode_o),
      .link_ready_o(link_ready_o), .fault_fatal_o(fault_fatal_o),
      .lane_tx_o(lane_tx), .lane_rx_i(lane_rx));

   always #50 aclk = ~aclk;                               // 100 ns period

   // ====================
   // Loopback and RX monitor
   // ====================
   assign inject_crc = inject_req != inject_ack;

   always @(posedge aclk) begin
      if (inject_crc && lane_tx[qeciphy_lane_pkg::LANE_W-1:qeciphy_lane_pkg::WORD_W] ==
          qeciphy_lane_pkg::HDR_DATA) begin
         lane_rx    <= lane_tx ^ 66'd1;                   // Flip payload bit 0
         inject_ack <= inject_ack + 1;
      end else begin
         lane_rx <= lane_tx;
      end
   end

   always @(negedge aclk) begin
      if (reset_i) begin
         rx_count = 0;
      end else if (rx_tvalid_o && rx_tready_i) begin      // Pops on the next edge
         if (rx_count >= expected.size()) begin
            stream_errs++;
            $display("ERROR t=%0t word %0h came out with none expected", $time, rx_tdata_o);
         end else if (rx_tdata_o !== expected[rx_count]) begin
            stream_errs++;
            $display("FAIL t=%0t rx_tdata_o got %0h expected %0h", $time, rx_tdata_o,
                     expected[rx_count]);
         end
         rx_count++;
      end
   end

   // ====================
   // Helpers
   // ====================
   function automatic logic [qeciphy_lane_pkg::WORD_W-1:0] next_word();
      next_word = {$random(seed), $random(seed)};
   endfunction

   task automatic report_value(input string name, input logic [65:0] got,
                               input logic [65:0] exp);
      value_errs++;
      $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
   endtask

   task automatic reset_dut();
      @(posedge aclk);
      reset_i     <= 1'b1;
      tx_tvalid_i <= 1'b0;
      rx_tready_i <= 1'b1;
      expected.delete();
      repeat (4) @(posedge aclk);
      reset_i <= 1'b0;
   endtask

   task automatic wait_link_up(output bit ok);
      int n;
      n = 0;
      @(negedge aclk);
      while (!link_ready_o && n < LINK_TIMEOUT) begin
         @(negedge aclk);
         n++;
      end
      ok = link_ready_o;
      if (!ok) begin
         other_errs++;
         $display("ERROR t=%0t link did not come up in %0d cycles", $time, LINK_TIMEOUT);
      end
   endtask

   task automatic send_word(input logic [qeciphy_lane_pkg::WORD_W-1:0] w, output bit ok);
      int n;
      n = 0;
      @(posedge aclk);
      tx_tdata_i  <= w;
      tx_tvalid_i <= 1'b1;
      @(negedge aclk);
      while (!tx_tready_o && n < SEND_TIMEOUT) begin      // Ready seen mid-cycle
         @(negedge aclk);
         n++;
      end
      ok = tx_tready_o;
      @(posedge aclk);                                    // Transfer edge when ok
      tx_tvalid_i <= 1'b0;
   endtask

   task automatic send_words(input int count);
      logic [qeciphy_lane_pkg::WORD_W-1:0] w;
      bit                                  ok;
      int                                  n;
      n  = 0;
      ok = 1'b1;
      while (n < count && ok) begin
         w = next_word();
         send_word(w, ok);
         if (ok) expected.push_back(w);
         n++;
      end
      if (!ok) begin
         other_errs++;
         $display("ERROR t=%0t TX stream never ready for word %0d", $time, n - 1);
      end
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while (rx_count < expected.size() && n < DRAIN_TIMEOUT) begin
         @(posedge aclk);                                 // Monitor counts on negedge
         n++;
      end
      if (rx_count < expected.size()) begin
         other_errs++;
         $display("ERROR t=%0t %0d sent words never came out", $time,
                  expected.size() - rx_count);
      end
   endtask

   task automatic wait_fault(output bit ok);
      int n;
      n = 0;
      @(negedge aclk);
      while (!fault_fatal_o && n < FAULT_TIMEOUT) begin
         @(negedge aclk);
         n++;
      end
      ok = fault_fatal_o;
      if (!ok) begin
         other_errs++;
         $display("ERROR t=%0t no fatal fault within %0d cycles", $time, FAULT_TIMEOUT);
      end
   endtask

   // ====================
   // Directed tests
   // ====================
   task automatic reset_values_test();
      reset_dut();
      @(negedge aclk);                                    // Still in RESET state
      if (tx_tready_o !== 1'b0) report_value("tx_tready_o", tx_tready_o, 0);
      if (rx_tvalid_o !== 1'b0) report_value("rx_tvalid_o", rx_tvalid_o, 0);
      if (link_ready_o !== 1'b0) report_value("link_ready_o", link_ready_o, 0);
      if (fault_fatal_o !== 1'b0) report_value("fault_fatal_o", fault_fatal_o, 0);
      if (status_o !== qeciphy_status_pkg::ST_RESET)
         report_value("status_o", status_o, qeciphy_status_pkg::ST_RESET);
      if (ecode_o !== qeciphy_status_pkg::EC_NONE)
         report_value("ecode_o", ecode_o, qeciphy_status_pkg::EC_NONE);
      if (lane_tx !== {qeciphy_lane_pkg::HDR_CTRL, qeciphy_lane_pkg::IDLE_WORD})
         report_value("lane_tx_o", lane_tx,
                      {qeciphy_lane_pkg::HDR_CTRL, qeciphy_lane_pkg::IDLE_WORD});
   endtask

   task automatic bring_up_test();
      bit ok;
      reset_dut();
      wait_link_up(ok);
      if (ok) begin
         if (status_o !== qeciphy_status_pkg::ST_LINK_UP)
            report_value("status_o", status_o, qeciphy_status_pkg::ST_LINK_UP);
         if (tx_tready_o !== 1'b1) report_value("tx_tready_o", tx_tready_o, 1);
         if (fault_fatal_o !== 1'b0) report_value("fault_fatal_o", fault_fatal_o, 0);
      end
   endtask

   task automatic data_integrity_test();
      bit ok;
      reset_dut();
      wait_link_up(ok);
      if (ok) begin
         send_words(40);                                  // RX ready stays high
         wait_drained();
      end
   endtask

   task automatic back_pressure_test();
      bit ok;
      int n;
      int drops;
      n     = 0;
      drops = 0;
      reset_dut();
      wait_link_up(ok);
      if (ok) begin
         @(posedge aclk);
         rx_tready_i <= 1'b0;
         send_words(20);
         @(negedge aclk);
         while (!rx_tvalid_o && n < DRAIN_TIMEOUT) begin
            @(negedge aclk);
            n++;
         end
         if (!rx_tvalid_o) report_value("rx_tvalid_o", rx_tvalid_o, 1);
         repeat (16) begin                                // Valid must hold while stalled
            @(negedge aclk);
            if (!rx_tvalid_o) drops++;
         end
         if (drops != 0) report_value("rx_tvalid_o", 0, 1);
         @(posedge aclk);
         rx_tready_i <= 1'b1;
         wait_drained();
         @(negedge aclk);
         if (ecode_o !== qeciphy_status_pkg::EC_NONE)
            report_value("ecode_o", ecode_o, qeciphy_status_pkg::EC_NONE);
      end
   endtask

   task automatic crc_error_test();
      bit ok;
      reset_dut();
      wait_link_up(ok);
      if (ok) begin
         @(posedge aclk);
         rx_tready_i <= 1'b0;                             // Keep the bad word in the FIFO
         inject_req  <= inject_req + 1;
         send_word(next_word(), ok);
         wait_fault(ok);
      end
      if (ok) begin
         @(negedge aclk);                                 // Controller follows a cycle later
         if (ecode_o !== qeciphy_status_pkg::EC_CRC)
            report_value("ecode_o", ecode_o, qeciphy_status_pkg::EC_CRC);
         if (status_o !== qeciphy_status_pkg::ST_FAULT)
            report_value("status_o", status_o, qeciphy_status_pkg::ST_FAULT);
         if (link_ready_o !== 1'b0) report_value("link_ready_o", link_ready_o, 0);
      end
   endtask

   task automatic rx_overflow_test();
      bit ok;
      int n;
      n = 0;
      reset_dut();
      wait_link_up(ok);
      if (ok) begin
         @(posedge aclk);
         rx_tready_i <= 1'b0;
         while (n < 40 && ok && !fault_fatal_o) begin     // TX stops once the fault hits
            send_word(next_word(), ok);
            n++;
         end
         wait_fault(ok);
      end
      if (ok) begin
         @(negedge aclk);                                 // Fault stays latched
         if (ecode_o !== qeciphy_status_pkg::EC_RX_OVERFLOW)
            report_value("ecode_o", ecode_o, qeciphy_status_pkg::EC_RX_OVERFLOW);
         if (fault_fatal_o !== 1'b1) report_value("fault_fatal_o", fault_fatal_o, 1);
      end
   endtask

   initial begin
      aclk        = 1'b0;
      reset_i     = 1'b1;
      tx_tdata_i  = '0;
      tx_tvalid_i = 1'b0;
      rx_tready_i = 1'b0;
      seed        = 32'h787838b2;
      rx_count    = 0;
      value_errs  = 0;
      stream_errs = 0;
      other_errs  = 0;
      reset_values_test();
      bring_up_test();
      data_integrity_test();
      back_pressure_test();
      crc_error_test();
      rx_overflow_test();
      $display("Errors: %0d value, %0d stream, %0d other", value_errs, stream_errs,
               other_errs);
      if (value_errs + stream_errs + other_errs == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// ==== hw/qeciphy_top.sv ====
// ====================
// PHY link layer top
// TX and RX word FIFOs, encoder, decoder
// Link controller, error handler, stream glue
// ====================
`timescale 1ns/1ns

module qeciphy_top (
   input  logic                                    aclk,
   input  logic                                    reset_i,
   input  logic [qeciphy_lane_pkg::WORD_W-1:0]     tx_tdata_i,
   input  logic                                    tx_tvalid_i,
   output logic                                    tx_tready_o,
   output logic [qeciphy_lane_pkg::WORD_W-1:0]     rx_tdata_o,
   output logic                                    rx_tvalid_o,
   input  logic                                    rx_tready_i,
   output logic [qeciphy_status_pkg::STATUS_W-1:0] status_o,
   output logic [qeciphy_status_pkg::ECODE_W-1:0]  ecode_o,
   output logic                                    link_ready_o,
   output logic                                    fault_fatal_o,
   output logic [qeciphy_lane_pkg::LANE_W-1:0]     lane_tx_o,
   input  logic [qeciphy_lane_pkg::LANE_W-1:0]     lane_rx_i
);

   logic [qeciphy_lane_pkg::WORD_W-1:0] tx_fifo_data, dec_data;
   logic tx_full, tx_empty, enc_pop;
   logic rx_empty, rx_overflow, dec_valid;
   logic locked, rx_ready, remote_ready, faw_err, crc_err;
   logic link_enable, data_enable, rx_enable;

   // ====================
   // Stream glue
   // ====================
   assign tx_tready_o = !tx_full && data_enable;      // Room and link up
   assign rx_tvalid_o = !rx_empty && link_ready_o;

   qeciphy_word_fifo u_tx_fifo (
      .aclk(aclk), .reset_i(reset_i), .wr_en_i(tx_tvalid_i && tx_tready_o),
      .wr_data_i(tx_tdata_i), .rd_en_i(enc_pop), .rd_data_o(tx_fifo_data),
      .full_o(tx_full), .empty_o(tx_empty), .overflow_o());   // Gated writes never overflow

   qeciphy_tx_encoder u_tx_encoder (
      .aclk(aclk), .reset_i(reset_i), .fifo_data_i(tx_fifo_data), .fifo_empty_i(tx_empty),
      .link_enable_i(link_enable), .data_enable_i(data_enable), .rx_ready_i(rx_ready),
      .fifo_pop_o(enc_pop), .lane_o(lane_tx_o));

   qeciphy_rx_decoder u_rx_decoder (
      .aclk(aclk), .reset_i(reset_i), .lane_i(lane_rx_i), .enable_i(rx_enable),
      .data_o(dec_data), .data_valid_o(dec_valid), .locked_o(locked), .rx_ready_o(rx_ready),
      .remote_ready_o(remote_ready), .faw_err_o(faw_err), .crc_err_o(crc_err));

   qeciphy_word_fifo u_rx_fifo (
      .aclk(aclk), .reset_i(reset_i), .wr_en_i(dec_valid), .wr_data_i(dec_data),
      .rd_en_i(rx_tvalid_o && rx_tready_i), .rd_data_o(rx_tdata_o),
      .full_o(), .empty_o(rx_empty), .overflow_o(rx_overflow));

   qeciphy_link_controller u_link_controller (
      .aclk(aclk), .reset_i(reset_i), .locked_i(locked), .rx_ready_i(rx_ready),
      .remote_ready_i(remote_ready), .fault_fatal_i(fault_fatal_o), .status_o(status_o),
      .link_ready_o(link_ready_o), .link_enable_o(link_enable),
      .data_enable_o(data_enable), .rx_enable_o(rx_enable));

   qeciphy_error_handler u_error_handler (
      .aclk(aclk), .reset_i(reset_i), .faw_err_i(faw_err), .crc_err_i(crc_err),
      .rx_overflow_i(rx_overflow), .fault_fatal_o(fault_fatal_o), .ecode_o(ecode_o));

endmodule

// ==== hw/qeciphy_error_handler.sv ====
// ====================
// First-error latch and fatal flag
// ====================
`timescale 1ns/1ns

module qeciphy_error_handler (
   input  logic                                   aclk,
   input  logic                                   reset_i,
   input  logic                                   faw_err_i,
   input  logic                                   crc_err_i,
   input  logic                                   rx_overflow_i,
   output logic                                   fault_fatal_o,
   output logic [qeciphy_status_pkg::ECODE_W-1:0] ecode_o
);

   always_ff @(posedge aclk) begin
      if (reset_i) begin
         fault_fatal_o <= 1'b0;
         ecode_o       <= qeciphy_status_pkg::EC_NONE;
      end else if (!fault_fatal_o) begin             // Only the first one counts
         fault_fatal_o <= faw_err_i || crc_err_i || rx_overflow_i;
         if (faw_err_i)          ecode_o <= qeciphy_status_pkg::EC_FAW_LOST;
         else if (crc_err_i)     ecode_o <= qeciphy_status_pkg::EC_CRC;
         else if (rx_overflow_i) ecode_o <= qeciphy_status_pkg::EC_RX_OVERFLOW;
      end
   end

   a_code_frozen : assert property (@(posedge aclk) disable iff (reset_i)
      fault_fatal_o |=> $stable(ecode_o));

endmodule

// ==== hw/qeciphy_link_controller.sv ====
// ====================
// Link bring-up FSM
// Status code and datapath enables
// ====================
`timescale 1ns/1ns

module qeciphy_link_controller (
   input  logic                                    aclk,
   input  logic                                    reset_i,
   input  logic                                    locked_i,
   input  logic                                    rx_ready_i,
   input  logic                                    remote_ready_i,
   input  logic                                    fault_fatal_i,
   output logic [qeciphy_status_pkg::STATUS_W-1:0] status_o,
   output logic                                    link_ready_o,
   output logic                                    link_enable_o,
   output logic                                    data_enable_o,
   output logic                                    rx_enable_o
);

   logic [qeciphy_status_pkg::STATUS_W-1:0] state_q;   // State doubles as status
   logic                                    link_up;

   always_ff @(posedge aclk) begin
      if (reset_i) begin
         state_q <= qeciphy_status_pkg::ST_RESET;
      end else if (fault_fatal_i) begin
         state_q <= qeciphy_status_pkg::ST_FAULT;       // Sticky until reset
      end else begin
         case (state_q)
            qeciphy_status_pkg::ST_RESET:       state_q <= qeciphy_status_pkg::ST_WAIT_LOCK;
            qeciphy_status_pkg::ST_WAIT_LOCK:
               if (locked_i && rx_ready_i) state_q <= qeciphy_status_pkg::ST_WAIT_REMOTE;
            qeciphy_status_pkg::ST_WAIT_REMOTE:
               if (remote_ready_i) state_q <= qeciphy_status_pkg::ST_LINK_UP;
            default:                            state_q <= state_q;
         endcase
      end
   end

   assign link_up       = state_q == qeciphy_status_pkg::ST_LINK_UP;
   assign status_o      = state_q;
   assign link_ready_o  = link_up;
   assign data_enable_o = link_up;
   assign link_enable_o = state_q != qeciphy_status_pkg::ST_RESET;  // Kept on in FAULT
   assign rx_enable_o   = (state_q == qeciphy_status_pkg::ST_WAIT_LOCK) ||
                          (state_q == qeciphy_status_pkg::ST_WAIT_REMOTE) || link_up;

endmodule

// ==== hw/qeciphy_rx_decoder.sv ====
// ====================
// RX channel decoder
// FAW hunt and lock, CRC check per frame
// Data word extraction and remote ready flag
// ====================
`timescale 1ns/1ns

module qeciphy_rx_decoder (
   input  logic                                aclk,
   input  logic                                reset_i,
   input  logic [qeciphy_lane_pkg::LANE_W-1:0] lane_i,
   input  logic                                enable_i,
   output logic [qeciphy_lane_pkg::WORD_W-1:0] data_o,
   output logic                                data_valid_o,
   output logic                                locked_o,
   output logic                                rx_ready_o,
   output logic                                remote_ready_o,
   output logic                                faw_err_o,
   output logic                                crc_err_o
);

   logic [qeciphy_lane_pkg::LANE_W-1:0] lane_q;
   logic [qeciphy_lane_pkg::SLOT_W-1:0] slot_q;      // Slot of the word in lane_q
   logic [1:0]                          faw_cnt_q;   // Spaced FAWs seen while hunting
   logic [qeciphy_lane_pkg::CRC_W-1:0]  crc_q;
   logic                                locked_q;
   logic [qeciphy_lane_pkg::HDR_W-1:0]  hdr;
   logic [qeciphy_lane_pkg::WORD_W-1:0] payload;
   logic                                is_faw;
   logic                                crc_ok;

   assign hdr     = lane_q[qeciphy_lane_pkg::LANE_W-1:qeciphy_lane_pkg::WORD_W];
   assign payload = lane_q[qeciphy_lane_pkg::WORD_W-1:0];
   assign is_faw  = (hdr == qeciphy_lane_pkg::HDR_CTRL) &&
                    (payload[63:1] == qeciphy_lane_pkg::FAW_MARK[63:1]);
   assign crc_ok  = (hdr == qeciphy_lane_pkg::HDR_CTRL) &&
                    (payload[63:16] == qeciphy_lane_pkg::CRC_MARK[63:16]) &&
                    (payload[15:0] == crc_q);
   assign locked_o = locked_q;

   always_ff @(posedge aclk) begin
      lane_q <= lane_i;                                 // Input stage
      data_o <= payload;
   end

   always_ff @(posedge aclk) begin
      if (reset_i || !enable_i) begin
         slot_q <= '0; // restart hunt
         faw_cnt_q      <= '0;
         crc_q          <= qeciphy_lane_pkg::CRC_INIT;
         locked_q       <= 1'b0;
         rx_ready_o     <= 1'b0;
         remote_ready_o <= 1'b0;
         data_valid_o   <= 1'b0;
         faw_err_o      <= 1'b0;
         crc_err_o      <= 1'b0;
      end else begin
         slot_q       <= is_faw ? qeciphy_lane_pkg::SLOT_W'(qeciphy_lane_pkg::SLOT_FIRST) :
                         (slot_q == qeciphy_lane_pkg::CRC_SLOT) ? '0 : slot_q + 1'b1;
         data_valid_o <= locked_q && (hdr == qeciphy_lane_pkg::HDR_DATA);
         faw_err_o    <= locked_q && (slot_q == '0) && !is_faw;      // FAW missing
         crc_err_o    <= locked_q && (slot_q == qeciphy_lane_pkg::CRC_SLOT) && !crc_ok;
         if (is_faw) remote_ready_o <= payload[0];                   // Far end RX state
         if (is_faw) crc_q <= qeciphy_lane_pkg::CRC_INIT;
         else if (slot_q >= qeciphy_lane_pkg::SLOT_FIRST && slot_q <= qeciphy_lane_pkg::SLOT_LAST)
            crc_q <= qeciphy_lane_pkg::crc_update(crc_q, payload);
         if (locked_q && slot_q == qeciphy_lane_pkg::CRC_SLOT && crc_ok)
            rx_ready_o <= 1'b1;                                       // First clean frame
         if (!locked_q) begin
            if (is_faw) begin
               if (faw_cnt_q != '0 && slot_q != '0) faw_cnt_q <= 2'd1; // Wrong spacing
               else if (faw_cnt_q == qeciphy_lane_pkg::LOCK_FAWS - 1) locked_q <= 1'b1;
               else faw_cnt_q <= faw_cnt_q + 2'd1;
            end else if (slot_q == '0) begin
               faw_cnt_q <= '0;                                        // Expected FAW absent
            end
         end
      end
   end

   // Nothing reaches the RX FIFO before frame lock
   a_valid_when_locked : assert property (@(posedge aclk) disable iff (reset_i)
      data_valid_o |-> locked_o);

endmodule

// ==== hw/qeciphy_tx_encoder.sv ====
// ====================
// TX channel encoder
// FAW at slot 0, six payload slots, CRC word at slot 7
// Empty slots carry IDLE
// ====================
`timescale 1ns/1ns

module qeciphy_tx_encoder (
   input  logic                                aclk,
   input  logic                                reset_i,
   input  logic [qeciphy_lane_pkg::WORD_W-1:0] fifo_data_i,
   input  logic                                fifo_empty_i,
   input  logic                                link_enable_i,
   input  logic                                data_enable_i,
   input  logic                                rx_ready_i,     // Local RX state to far end
   output logic                                fifo_pop_o,
   output logic [qeciphy_lane_pkg::LANE_W-1:0] lane_o
);

   logic [qeciphy_lane_pkg::SLOT_W-1:0] slot_q;
   logic [qeciphy_lane_pkg::CRC_W-1:0]  crc_q;      // Running CRC over the slots
   logic                                data_slot;

   assign data_slot  = (slot_q >= qeciphy_lane_pkg::SLOT_FIRST) &&
                       (slot_q <= qeciphy_lane_pkg::SLOT_LAST);
   assign fifo_pop_o = link_enable_i && data_enable_i && data_slot && !fifo_empty_i;

   // ====================
   // Slot sequencer
   // ====================
   always_ff @(posedge aclk) begin
      if (reset_i || !link_enable_i) begin                 // Idle and restart the frame
         slot_q <= '0;
         crc_q  <= qeciphy_lane_pkg::CRC_INIT;
         lane_o <= {qeciphy_lane_pkg::HDR_CTRL, qeciphy_lane_pkg::IDLE_WORD};
      end else begin
         slot_q <= (slot_q == qeciphy_lane_pkg::CRC_SLOT) ? '0 : slot_q + 1'b1;
         if (slot_q == '0) begin                           // Alignment word
            lane_o <= {qeciphy_lane_pkg::HDR_CTRL,
                       qeciphy_lane_pkg::FAW_MARK[qeciphy_lane_pkg::WORD_W-1:1],
                       rx_ready_i};
            crc_q  <= qeciphy_lane_pkg::CRC_INIT;
         end else if (slot_q == qeciphy_lane_pkg::CRC_SLOT) begin
            lane_o <= {qeciphy_lane_pkg::HDR_CTRL,
                       qeciphy_lane_pkg::CRC_MARK[qeciphy_lane_pkg::WORD_W-1:
                                                  qeciphy_lane_pkg::CRC_W],
                       crc_q};
         end else if (fifo_pop_o) begin                    // User word
            lane_o <= {qeciphy_lane_pkg::HDR_DATA, fifo_data_i};
            crc_q  <= qeciphy_lane_pkg::crc_update(crc_q, fifo_data_i);
         end else begin                                    // Nothing to send
            lane_o <= {qeciphy_lane_pkg::HDR_CTRL, qeciphy_lane_pkg::IDLE_WORD};
            crc_q  <= qeciphy_lane_pkg::crc_update(crc_q, qeciphy_lane_pkg::IDLE_WORD);
         end
      end
   end

   // No user word leaves while data is disabled
   a_no_data_when_disabled : assert property (@(posedge aclk) disable iff (reset_i)
      !data_enable_i |=> lane_o[qeciphy_lane_pkg::LANE_W-1:qeciphy_lane_pkg::WORD_W] !=
                         qeciphy_lane_pkg::HDR_DATA);

endmodule

// ==== hw/qeciphy_word_fifo.sv ====
// ====================
// Synchronous first-word-fall-through FIFO
// Full, empty and overflow flags
// ====================
`timescale 1ns/1ns

module qeciphy_word_fifo #(
   parameter int ADDR_W = qeciphy_lane_pkg::FIFO_AW
) (
   input  logic                                aclk,
   input  logic                                reset_i,
   input  logic                                wr_en_i,
   input  logic [qeciphy_lane_pkg::WORD_W-1:0] wr_data_i,
   input  logic                                rd_en_i,
   output logic [qeciphy_lane_pkg::WORD_W-1:0] rd_data_o,
   output logic                                full_o,
   output logic                                empty_o,
   output logic                                overflow_o
);

   logic [qeciphy_lane_pkg::WORD_W-1:0] mem [2**ADDR_W];
   logic [ADDR_W:0]                     wr_ptr_q;   // Extra wrap bit
   logic [ADDR_W:0]                     rd_ptr_q;

   assign empty_o    = wr_ptr_q == rd_ptr_q;
   assign full_o     = (wr_ptr_q[ADDR_W] != rd_ptr_q[ADDR_W]) &&
                       (wr_ptr_q[ADDR_W-1:0] == rd_ptr_q[ADDR_W-1:0]);
   assign overflow_o = wr_en_i && full_o;                // Rejected write
   assign rd_data_o  = mem[rd_ptr_q[ADDR_W-1:0]];        // Head word shows at once

   always_ff @(posedge aclk) begin
      if (wr_en_i && !full_o) mem[wr_ptr_q[ADDR_W-1:0]] <= wr_data_i;
   end

   always_ff @(posedge aclk) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (wr_en_i && !full_o) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (rd_en_i && !empty_o) rd_ptr_q <= rd_ptr_q + 1'b1;
      end
   end

   // Callers only pop a word they can see
   a_no_underflow : assert property (@(posedge aclk) disable iff (reset_i)
      rd_en_i |-> !empty_o);

endmodule

// ==== hw/qeciphy_status_pkg.sv ====
// ====================
// Link status codes and error codes
// ====================
package qeciphy_status_pkg;

   localparam int STATUS_W = 4;

   localparam logic [STATUS_W-1:0] ST_RESET       = 4'd0;
   localparam logic [STATUS_W-1:0] ST_WAIT_LOCK   = 4'd1; // Hunting for FAW
   localparam logic [STATUS_W-1:0] ST_WAIT_REMOTE = 4'd2; // Waiting for far end
   localparam logic [STATUS_W-1:0] ST_LINK_UP     = 4'd3;
   localparam logic [STATUS_W-1:0] ST_FAULT       = 4'd4; // Left only by reset

   localparam int ECODE_W = 4;

   localparam logic [ECODE_W-1:0] EC_NONE        = 4'd0;
   localparam logic [ECODE_W-1:0] EC_FAW_LOST    = 4'd1; // Lowest code wins
   localparam logic [ECODE_W-1:0] EC_CRC         = 4'd2;
   localparam logic [ECODE_W-1:0] EC_RX_OVERFLOW = 4'd3;

endpackage

// ==== hw/qeciphy_lane_pkg.sv ====
// ====================
// Lane framing constants for the PHY link layer
// Header codes, FAW, IDLE and CRC marks, frame slots
// CRC-16 update function over one payload word
// ====================
package qeciphy_lane_pkg;

   localparam int WORD_W = 64;                 // User and payload width
   localparam int HDR_W  = 2;                  // Sync header
   localparam int LANE_W = WORD_W + HDR_W;     // Full lane word

   localparam logic [HDR_W-1:0]  HDR_DATA  = 2'b01;                  // User payload
   localparam logic [HDR_W-1:0]  HDR_CTRL  = 2'b10;                  // FAW, IDLE, CRC
   localparam logic [WORD_W-1:0] FAW_MARK  = 64'hF0F0_CAFE_5A5A_3C3C; // Bit 0 is RX-ready flag
   localparam logic [WORD_W-1:0] IDLE_WORD = 64'h0707_0707_0707_0707;
   localparam logic [WORD_W-1:0] CRC_MARK  = 64'hC3C3_C3C3_C3C3_0000; // Low bits hold CRC

   localparam int FRAME_LEN  = 8;              // Words per frame
   localparam int SLOT_W     = 3;              // Slot counter width
   localparam int SLOT_FIRST = 1;
   localparam int SLOT_LAST  = 6;
   localparam int CRC_SLOT   = 7;

   localparam int                CRC_W    = 16;
   localparam logic [CRC_W-1:0]  CRC_POLY = 16'h1021; // CCITT polynomial
   localparam logic [CRC_W-1:0]  CRC_INIT = 16'hFFFF;

   localparam int LOCK_FAWS = 3;               // Well-spaced FAWs for lock
   localparam int FIFO_AW   = 5;               // Depth of 32

   // Bitwise fold, MSB first
   function automatic logic [CRC_W-1:0] crc_update(input logic [CRC_W-1:0]  crc,
                                                   input logic [WORD_W-1:0] data);
      logic [CRC_W-1:0] c;
      logic             fb;
      c = crc;
      for (int i = WORD_W - 1; i >= 0; i--) begin
         fb = c[CRC_W-1] ^ data[i];               // Feedback bit
         c  = {c[CRC_W-2:0], 1'b0};
         if (fb) c = c ^ CRC_POLY;
      end
      return c;
   endfunction

endpackage
